/* build.f */
hdl/cfg_map_pkg.sv
hdl/dispatch_pkg.sv
hdl/sample_fifo.sv
hdl/route_config.sv
hdl/instr_dispatch.sv
hdl/pid_dispatch_top.sv
tests/dispatch_properties.sv
tests/tb_pid_dispatch.sv

/* Makefile */
# Verilator build and run for the PID dispatch front end

VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_pid_dispatch
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the simulation output holds the pass message
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_pid_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pid_dispatch
   import cfg_map_pkg::*;
();

   localparam int N_CHAN       = 8;
   localparam int W_SRC        = 5;
   localparam int W_DATA       = 18;
   localparam int FIFO_DEPTH   = 16;
   localparam int W_CHAN       = $clog2(N_CHAN);
   localparam int RESET_CYCLES = 4;
   localparam int K_WR         = 0;
   localparam int K_SMP        = 1;

   // One table row is a configuration write or a sample
   // exp_cnt is the number of instructions the sample must produce
   // b2b keeps the sample strobe going into the next row without a wait
   typedef struct {
      string                 name;
      int                    kind;
      logic [CFG_ADDR_W-1:0] addr;
      int                    chan;
      logic [CFG_DATA_W-1:0] wdata;
      logic [W_SRC-1:0]      src;
      bit                    b2b;
      int                    exp_cnt;
   } entry_t;

   entry_t tbl[$];

   logic                  clk_in;
   logic                  arst_n;
   logic                  dv;
   logic [W_SRC-1:0]      src;
   logic [W_DATA-1:0]     data;
   logic                  wr_en;
   logic [CFG_ADDR_W-1:0] wr_addr;
   logic [CFG_CHAN_W-1:0] wr_chan;
   logic [CFG_DATA_W-1:0] wr_data;
   logic                  dv_out;
   logic [W_CHAN-1:0]     chan_out;
   logic [W_DATA-1:0]     data_out;
   logic                  full;
   logic                  busy;

   // Reference copy of the routing table and the expected instructions
   logic [W_SRC-1:0]  ref_src [N_CHAN];
   bit                ref_routed [N_CHAN];
   bit                ref_en [N_CHAN];
   int                exp_chan_q[$];
   logic [W_DATA-1:0] exp_data_q[$];

   int                value_errs;
   int                other_errs;
   int                seen_cnt;
   int                exp_total;
   int                cycles;
   int                limit;
   int                want_chan;
   logic [W_DATA-1:0] want_data;
   logic [W_DATA-1:0] smp_data;
   logic [31:0]       lfsr;
   string             cur_name;

   pid_dispatch_top #(
      .N_CHAN     (N_CHAN),
      .W_SRC      (W_SRC),
      .W_DATA     (W_DATA),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) dut (
      .clk_in   (clk_in),
      .arst_n   (arst_n),
      .dv       (dv),
      .src      (src),
      .data     (data),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_chan  (wr_chan),
      .wr_data  (wr_data),
      .dv_out   (dv_out),
      .chan_out (chan_out),
      .data_out (data_out),
      .full     (full),
      .busy     (busy)
   );

   initial begin
      clk_in = 1'b0;
      forever #50 clk_in = ~clk_in;
   end

   //--------------------------------------------------------------------------
   // Table construction
   //--------------------------------------------------------------------------
   task automatic add_write(input string name, input logic [CFG_ADDR_W-1:0] addr,
                            input int chan, input logic [CFG_DATA_W-1:0] wdata);
      entry_t e;
      e.name    = name;
      e.kind    = K_WR;
      e.addr    = addr;
      e.chan    = chan;
      e.wdata   = wdata;
      e.src     = '0;
      e.b2b     = 1'b0;
      e.exp_cnt = 0;
      tbl.push_back(e);
   endtask

   task automatic add_sample(input string name, input int s, input bit b2b, input int exp_cnt);
      entry_t e;
      e.name    = name;
      e.kind    = K_SMP;
      e.addr    = '0;
      e.chan    = 0;
      e.wdata   = '0;
      e.src     = W_SRC'(s);
      e.b2b     = b2b;
      e.exp_cnt = exp_cnt;
      tbl.push_back(e);
   endtask

   task automatic build_table();
      // Nothing is routed after reset
      add_sample("no_cfg", 0, 1'b0, 0);
      add_sample("no_cfg", 3, 1'b0, 0);
      // Source select data is the routed bit at 16 over the source number
      add_write("single", CFG_CHAN_SRC_SEL, 2, 32'h0001_0003);
      add_write("single", CFG_CHAN_EN, 2, 32'h0000_0001);
      add_sample("single", 3, 1'b0, 1);
      add_sample("single", 4, 1'b0, 0);
      add_write("multi", CFG_CHAN_SRC_SEL, 0, 32'h0001_0003);
      add_write("multi", CFG_CHAN_EN, 0, 32'h0000_0001);
      add_write("multi", CFG_CHAN_SRC_SEL, 5, 32'h0001_0003);
      add_write("multi", CFG_CHAN_EN, 5, 32'h0000_0001);
      add_sample("multi", 3, 1'b0, 3);
      // Channel 2 disabled and channel 7 routed but never enabled
      add_write("disabled", CFG_CHAN_EN, 2, 32'h0000_0000);
      add_write("disabled", CFG_CHAN_SRC_SEL, 7, 32'h0001_0003);
      add_sample("disabled", 3, 1'b0, 2);
      add_write("remap", CFG_CHAN_SRC_SEL, 5, 32'h0001_0006);
      add_sample("remap", 3, 1'b0, 1);
      add_sample("remap", 6, 1'b0, 1);
      // Unknown address and out of range channel leave the table alone
      add_write("remap", 16'h0020, 0, 32'h0001_0007);
      add_sample("remap", 3, 1'b0, 1);
      add_write("remap", CFG_CHAN_SRC_SEL, N_CHAN, 32'h0001_0003);
      add_sample("remap", 3, 1'b0, 1);
      // Clearing the routed bit unroutes channel 0
      add_write("remap", CFG_CHAN_SRC_SEL, 0, 32'h0000_0003);
      add_sample("remap", 3, 1'b0, 0);
      // A full buffer's worth of samples on consecutive cycles
      add_write("burst", CFG_CHAN_SRC_SEL, 1, 32'h0001_0009);
      add_write("burst", CFG_CHAN_EN, 1, 32'h0000_0001);
      add_write("burst", CFG_CHAN_SRC_SEL, 4, 32'h0001_0009);
      add_write("burst", CFG_CHAN_EN, 4, 32'h0000_0001);
      for (int k = 0; k < FIFO_DEPTH; k++) begin
         add_sample("burst", 9, k != FIFO_DEPTH - 1, 2);
      end
   endtask

   //--------------------------------------------------------------------------
   // Stimulus data and reference model
   //--------------------------------------------------------------------------
   // Galois form that shifts right and applies the feedback mask on a one
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // Each data bit comes from its own LFSR step
   task automatic draw_data(output logic [W_DATA-1:0] d);
      for (int b = 0; b < W_DATA; b++) begin
         lfsr = lfsr_step(lfsr);
         d[b] = lfsr[0];
      end
   endtask

   task automatic ref_write(input entry_t e);
      if (e.chan < N_CHAN) begin
         if (e.addr == CFG_CHAN_SRC_SEL) begin
            ref_src[e.chan]    = e.wdata[W_SRC-1:0];
            ref_routed[e.chan] = e.wdata[CFG_ROUTED_BIT];
         end else if (e.addr == CFG_CHAN_EN) begin
            ref_en[e.chan] = e.wdata[CFG_EN_BIT];
         end
      end
   endtask

   // Enabled channels routed to the source, lowest channel first
   task automatic ref_sample(input logic [W_SRC-1:0] s, input logic [W_DATA-1:0] d);
      for (int c = 0; c < N_CHAN; c++) begin
         if (ref_routed[c] && ref_en[c] && ref_src[c] == s) begin
            exp_chan_q.push_back(c);
            exp_data_q.push_back(d);
         end
      end
   endtask

   //--------------------------------------------------------------------------
   // Monitor and watchdog
   //--------------------------------------------------------------------------
   // Outputs change on the rising edge, so they are read on the falling one
   always @(negedge clk_in) begin
      if (arst_n && dv_out) begin
         seen_cnt++;
         assert (exp_chan_q.size() != 0) else begin
            other_errs++;
            $display("%s: instruction on channel %0d was not expected", cur_name, chan_out);
         end
         if (exp_chan_q.size() != 0) begin
            want_chan = exp_chan_q.pop_front();
            want_data = exp_data_q.pop_front();
            assert (int'(chan_out) == want_chan) else begin
               value_errs++;
               $display("Fail %s: chan_out expected %0d actual %0d",
                        cur_name, want_chan, chan_out);
            end
            assert (data_out == want_data) else begin
               value_errs++;
               $display("Fail %s: data_out expected 0x%05h actual 0x%05h",
                        cur_name, want_data, data_out);
            end
         end
      end
   end

   always @(posedge clk_in) begin
      cycles++;
      if (cycles > limit) begin
         $display("Timeout: the run did not finish within %0d cycles", limit);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   //--------------------------------------------------------------------------
   // Main sequence
   //--------------------------------------------------------------------------
   initial begin
      arst_n     = 1'b0;
      dv         = 1'b0;
      src        = '0;
      data       = '0;
      wr_en      = 1'b0;
      wr_addr    = '0;
      wr_chan    = '0;
      wr_data    = '0;
      value_errs = 0;
      other_errs = 0;
      seen_cnt   = 0;
      exp_total  = 0;
      cycles     = 0;
      lfsr       = 32'd94040;
      cur_name   = "reset";
      build_table();
      limit = tbl.size() * (N_CHAN + 4) + RESET_CYCLES;

      // Reset spans a fixed number of rising edges and ends on a falling one
      repeat (RESET_CYCLES) @(posedge clk_in);
      @(negedge clk_in);
      arst_n = 1'b1;
      assert (!dv_out && !full && !busy) else begin
         value_errs++;
         $display("Fail reset: dv_out full busy expected 000 actual %b%b%b", dv_out, full, busy);
      end

      foreach (tbl[i]) begin
         cur_name = tbl[i].name;
         if (tbl[i].kind == K_WR) begin
            ref_write(tbl[i]);
            wr_en   = 1'b1;
            wr_addr = tbl[i].addr;
            wr_chan = CFG_CHAN_W'(tbl[i].chan);
            wr_data = tbl[i].wdata;
            @(negedge clk_in);
            wr_en = 1'b0;
         end else begin
            draw_data(smp_data);
            ref_sample(tbl[i].src, smp_data);
            exp_total += tbl[i].exp_cnt;
            dv   = 1'b1;
            src  = tbl[i].src;
            data = smp_data;
            @(negedge clk_in);
            dv = 1'b0;
            // busy covers every cycle in which dv_out can be high
            if (!tbl[i].b2b) begin
               while (busy) @(negedge clk_in);
               assert (seen_cnt == exp_total) else begin
                  value_errs++;
                  $display("Fail %s: instruction count expected %0d actual %0d",
                           cur_name, exp_total, seen_cnt);
               end
               seen_cnt  = 0;
               exp_total = 0;
            end
         end
      end

      assert (exp_chan_q.size() == 0) else begin
         other_errs++;
         $display("%0d expected instructions never appeared", exp_chan_q.size());
      end
      $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if (value_errs + other_errs == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tests/dispatch_properties.sv */
`timescale 1ns/1ps
`default_nettype none

// Protocol properties of the instruction dispatcher
// Bound into every instance of instr_dispatch
module dispatch_properties
   import dispatch_pkg::*;
#(
   parameter int N_CHAN  = 8,
   localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
   input wire logic              clk_in,
   input wire logic              arst_n,
   input wire logic [1:0]        state,
   input wire logic              pop,
   input wire logic              head_valid,
   input wire logic              dv_out,
   input wire logic [W_CHAN-1:0] chan_out
);

   // A pop may only release a sample that is really at the head
   pop_only_with_head: assert property (@(posedge clk_in) disable iff (!arst_n)
      pop |-> head_valid)
      else $error("pop raised with no sample at the head of the buffer");

   // Every issued instruction names an existing channel
   chan_in_range: assert property (@(posedge clk_in) disable iff (!arst_n)
      dv_out |-> (int'(chan_out) < N_CHAN))
      else $error("instruction issued for a channel number that does not exist");

   // No instruction strobe while the reset is held
   dv_low_in_reset: assert property (@(posedge clk_in)
      !arst_n |-> !dv_out)
      else $error("dv_out high while reset is asserted");

   // The fourth state encoding is never reached
   state_legal: assert property (@(posedge clk_in) disable iff (!arst_n)
      state inside {DISP_IDLE, DISP_SCAN, DISP_POP})
      else $error("dispatcher FSM left its legal states");

endmodule

bind instr_dispatch dispatch_properties #(
   .N_CHAN (N_CHAN)
) u_dispatch_properties (
   .clk_in     (clk_in),
   .arst_n     (arst_n),
   .state      (state),
   .pop        (pop),
   .head_valid (head_valid),
   .dv_out     (dv_out),
   .chan_out   (chan_out)
);

`default_nettype wire

/* hdl/pid_dispatch_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Dispatch front end of the multi-channel PID controller
// The input buffer and the routing table run side by side, and the
// dispatcher combines the head sample with the routing
module pid_dispatch_top
   import cfg_map_pkg::*;
#(
   parameter int N_CHAN     = 8,
   parameter int W_SRC      = 5,
   parameter int W_DATA     = 18,
   parameter int FIFO_DEPTH = 16,
   localparam int W_CHAN    = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
   input  wire logic                  clk_in,
   input  wire logic                  arst_n,
   // ADC sample strobe
   input  wire logic                  dv,
   input  wire logic [W_SRC-1:0]      src,
   input  wire logic [W_DATA-1:0]     data,
   // Configuration write strobe
   input  wire logic                  wr_en,
   input  wire logic [CFG_ADDR_W-1:0] wr_addr,
   input  wire logic [CFG_CHAN_W-1:0] wr_chan,
   input  wire logic [CFG_DATA_W-1:0] wr_data,
   // Instruction strobe toward the PID pipeline
   output logic                       dv_out,
   output logic [W_CHAN-1:0]          chan_out,
   output logic [W_DATA-1:0]          data_out,
   // Status levels
   output logic                       full,
   output logic                       busy
);

   //-----------------------------------------------------------------------
   // Internal nets
   //-----------------------------------------------------------------------
   logic                    head_valid;
   logic [W_SRC-1:0]        head_src;
   logic [W_DATA-1:0]       head_data;
   logic                    pop;
   logic                    active;
   logic [N_CHAN*W_SRC-1:0] src_sel;
   logic [N_CHAN-1:0]       routed;
   logic [N_CHAN-1:0]       chan_en;

   sample_fifo #(
      .W_SRC      (W_SRC),
      .W_DATA     (W_DATA),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_sample_fifo (
      .clk_in     (clk_in),
      .arst_n     (arst_n),
      .push       (dv),
      .push_src   (src),
      .push_data  (data),
      .pop        (pop),
      .head_valid (head_valid),
      .head_src   (head_src),
      .head_data  (head_data),
      .full       (full)
   );

   route_config #(
      .N_CHAN (N_CHAN),
      .W_SRC  (W_SRC)
   ) u_route_config (
      .clk_in  (clk_in),
      .arst_n  (arst_n),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_chan (wr_chan),
      .wr_data (wr_data),
      .src_sel (src_sel),
      .routed  (routed),
      .chan_en (chan_en)
   );

   instr_dispatch #(
      .N_CHAN (N_CHAN),
      .W_SRC  (W_SRC),
      .W_DATA (W_DATA)
   ) u_instr_dispatch (
      .clk_in     (clk_in),
      .arst_n     (arst_n),
      .head_valid (head_valid),
      .head_src   (head_src),
      .head_data  (head_data),
      .src_sel    (src_sel),
      .routed     (routed),
      .chan_en    (chan_en),
      .pop        (pop),
      .active     (active),
      .dv_out     (dv_out),
      .chan_out   (chan_out),
      .data_out   (data_out)
   );

   // Busy while a sample waits or the dispatcher is still working on one
   assign busy = head_valid | active;

endmodule

`default_nettype wire

/* hdl/instr_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

// Instruction dispatcher
// Takes the sample at the head of the input buffer and issues one
// instruction for every output channel routed to its source, lowest
// channel first, then releases the sample
module instr_dispatch
   import dispatch_pkg::*;
#(
   parameter int N_CHAN = 8,
   parameter int W_SRC  = 5,
   parameter int W_DATA = 18,
   localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
   input  wire logic                    clk_in,
   input  wire logic                    arst_n,
   input  wire logic                    head_valid,
   input  wire logic [W_SRC-1:0]        head_src,
   input  wire logic [W_DATA-1:0]       head_data,
   input  wire logic [N_CHAN*W_SRC-1:0] src_sel,
   input  wire logic [N_CHAN-1:0]       routed,
   input  wire logic [N_CHAN-1:0]       chan_en,
   output logic                         pop,
   output logic                         active,
   output logic                         dv_out,
   output logic [W_CHAN-1:0]            chan_out,
   output logic [W_DATA-1:0]            data_out
);

   disp_state_e       state;
   // One bit per channel, set once that channel has had its instruction
   logic [N_CHAN-1:0] sent;

   //-----------------------------------------------------------------------
   // Channel match and priority select
   //-----------------------------------------------------------------------
   logic [N_CHAN-1:0] match;
   logic [N_CHAN-1:0] left_after;
   logic [W_CHAN-1:0] sel_chan;
   logic              found;
   logic              more_left;

   // A channel is a candidate when it is routed to the head source and
   // has not been served for this sample yet
   always_comb begin
      for (int i = 0; i < N_CHAN; i++) begin
         match[i] = routed[i] && !sent[i] && (src_sel[i*W_SRC +: W_SRC] == head_src);
      end
   end

   // Walk from the top down so the lowest matching channel wins
   always_comb begin
      sel_chan = '0;
      found    = 1'b0;
      for (int i = N_CHAN - 1; i >= 0; i--) begin
         if (match[i]) begin
            sel_chan = W_CHAN'(i);
            found    = 1'b1;
         end
      end
   end

   // Looking one channel ahead lets the last instruction and the move to
   // POP share a cycle, so k routed channels cost k scan cycles
   assign left_after = match & ~(N_CHAN'(1) << sel_chan);
   assign more_left  = (left_after != '0);

   //-----------------------------------------------------------------------
   // FSM and sent-channel bitmap
   //-----------------------------------------------------------------------
   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n) begin
         state  <= DISP_IDLE;
         sent   <= '0;
         dv_out <= 1'b0;
      end else begin
         // The instruction strobe lasts a single cycle
         dv_out <= 1'b0;
         case (state)
            DISP_IDLE: begin
               if (head_valid) begin
                  state <= DISP_SCAN;
               end
            end
            DISP_SCAN: begin
               if (found) begin
                  // Disabled channels are still marked as served
                  sent[sel_chan] <= 1'b1;
                  dv_out         <= chan_en[sel_chan];
               end
               if (!found || !more_left) begin
                  state <= DISP_POP;
               end
            end
            DISP_POP: begin
               // Clearing here lets the next sample start scanning fresh
               sent  <= '0;
               state <= DISP_IDLE;
            end
            default: begin
               state <= DISP_IDLE;
            end
         endcase
      end
   end

   // Instruction payload that dv_out qualifies
   always_ff @(posedge clk_in) begin
      if (state == DISP_SCAN && found) begin
         chan_out <= sel_chan;
         data_out <= head_data;
      end
   end

   //-----------------------------------------------------------------------
   // Outputs decoded from the state
   //-----------------------------------------------------------------------
   // The head cannot change before POP, so head_valid still holds here
   assign pop    = (state == DISP_POP);
   assign active = (state != DISP_IDLE);

endmodule

`default_nettype wire

/* hdl/route_config.sv */
`timescale 1ns/1ps
`default_nettype none

// Configuration register file for the output channels
// For every channel it keeps the ADC source that drives it, a routed bit
// and an enable bit, all written through single-cycle strobes
module route_config
   import cfg_map_pkg::*;
#(
   parameter int N_CHAN = 8,
   parameter int W_SRC  = 5
) (
   input  wire logic                  clk_in,
   input  wire logic                  arst_n,
   input  wire logic                  wr_en,
   input  wire logic [CFG_ADDR_W-1:0] wr_addr,
   input  wire logic [CFG_CHAN_W-1:0] wr_chan,
   input  wire logic [CFG_DATA_W-1:0] wr_data,
   output logic [N_CHAN*W_SRC-1:0]    src_sel,
   output logic [N_CHAN-1:0]          routed,
   output logic [N_CHAN-1:0]          chan_en
);

   localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;

   //-----------------------------------------------------------------------
   // Write decode
   //-----------------------------------------------------------------------
   logic              chan_ok;
   logic [W_CHAN-1:0] chan_idx;

   // Channel numbers past the last channel are dropped
   assign chan_ok  = (wr_chan < CFG_CHAN_W'(N_CHAN));
   assign chan_idx = wr_chan[W_CHAN-1:0];

   //-----------------------------------------------------------------------
   // Register file
   //-----------------------------------------------------------------------
   // Channel n owns bits n*W_SRC and up of the flat source select vector
   // After reset every channel is unrouted and disabled
   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n) begin
         src_sel <= '0;
         routed  <= '0;
         chan_en <= '0;
      end else if (wr_en && chan_ok) begin
         case (wr_addr)
            CFG_CHAN_SRC_SEL: begin
               // Source number and routed bit always change together
               src_sel[chan_idx*W_SRC +: W_SRC] <= wr_data[W_SRC-1:0];
               routed[chan_idx]                 <= wr_data[CFG_ROUTED_BIT];
            end
            CFG_CHAN_EN: begin
               chan_en[chan_idx] <= wr_data[CFG_EN_BIT];
            end
            default: begin
               // Unknown addresses leave the table as it is
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/sample_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// Input buffer for ADC samples
// Each entry holds the source number and the data word of one sample
// The oldest entry is shown on the head outputs without a read request
module sample_fifo #(
   parameter int W_SRC      = 5,
   parameter int W_DATA     = 18,
   parameter int FIFO_DEPTH = 16
) (
   input  wire logic              clk_in,
   input  wire logic              arst_n,
   input  wire logic              push,
   input  wire logic [W_SRC-1:0]  push_src,
   input  wire logic [W_DATA-1:0] push_data,
   input  wire logic              pop,
   output logic                   head_valid,
   output logic [W_SRC-1:0]       head_src,
   output logic [W_DATA-1:0]      head_data,
   output logic                   full
);

   // Depth is a power of two so the pointers wrap on their own
   localparam int W_PTR  = $clog2(FIFO_DEPTH);
   localparam int W_WORD = W_SRC + W_DATA;

   //-----------------------------------------------------------------------
   // Storage and pointers
   //-----------------------------------------------------------------------
   logic [W_WORD-1:0] mem [FIFO_DEPTH];
   logic [W_PTR-1:0]  wr_ptr;
   logic [W_PTR-1:0]  rd_ptr;
   // One extra bit so a full buffer can be told apart from an empty one
   logic [W_PTR:0]    count;

   logic do_push;
   logic do_pop;

   // A push while full is dropped and a pop on an empty buffer does nothing
   assign do_push = push && !full;
   assign do_pop  = pop && head_valid;

   // Every accepted push stores its sample at the write pointer
   always_ff @(posedge clk_in) begin
      if (do_push) begin
         mem[wr_ptr] <= {push_src, push_data};
      end
   end

   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Occupancy only moves when exactly one side is active
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   //-----------------------------------------------------------------------
   // Head and status outputs
   //-----------------------------------------------------------------------
   // A word written into an empty buffer shows up here one edge later
   assign head_valid = (count != '0);
   assign full       = (count == (W_PTR+1)'(FIFO_DEPTH));

   // Fall-through read of the oldest entry
   assign {head_src, head_data} = mem[rd_ptr];

endmodule

`default_nettype wire

/* hdl/dispatch_pkg.sv */
`default_nettype none

//--------------------------------------------------------------------------
// Types private to the instruction dispatcher
//--------------------------------------------------------------------------
package dispatch_pkg;

   // Dispatcher FSM states
   // IDLE waits for a sample at the head of the input buffer
   // SCAN issues one instruction per cycle for each routed channel
   // POP releases the head sample and clears the sent-channel bitmap
   // The fourth encoding is unused and never reached
   typedef enum logic [1:0] {
      DISP_IDLE = 2'd0,
      DISP_SCAN = 2'd1,
      DISP_POP  = 2'd2
   } disp_state_e;

endpackage

`default_nettype wire

/* hdl/cfg_map_pkg.sv */
`default_nettype none

//--------------------------------------------------------------------------
// Configuration register map of the dispatch front end
//--------------------------------------------------------------------------
package cfg_map_pkg;

   // Widths of the configuration write port
   localparam int CFG_ADDR_W = 16;
   localparam int CFG_CHAN_W = 16;
   localparam int CFG_DATA_W = 32;

   // Bit positions inside wr_data
   // The source number sits in the low bits, starting at bit 0
   localparam int CFG_ROUTED_BIT = 16;
   localparam int CFG_EN_BIT     = 0;

   // Register addresses
   // A source select write carries the source number and the routed bit
   // An enable write carries the enable bit only
   // Every other address is ignored by the register file
   typedef enum logic [CFG_ADDR_W-1:0] {
      CFG_CHAN_SRC_SEL = 16'h0010,
      CFG_CHAN_EN      = 16'h0011
   } cfg_addr_e;

endpackage

`default_nettype wire
